// ==== logic/capture_pkg.sv ====
package capture_pkg;

	////////////////////////////////////////
	// Limits and sizes
	////////////////////////////////////////
	localparam int H_WIN_FIRST     = 221;   // First captured hcount
	localparam int H_WIN_LAST      = 1420;  // Last captured hcount
	localparam int ADE_PACKET_LEN  = 32;    // Cycles per aux packet
	localparam int FIFO_DEPTH_LOG2 = 4;
	localparam int PAYLOAD_W       = 48;    // Widest record, pixel

	////////////////////////////////////////
	// Scalar types
	////////////////////////////////////////
	typedef logic [10:0] pix_count_t;   // Horizontal position
	typedef logic [10:0] line_count_t;  // Line within frame
	typedef logic [11:0] pix_index_t;   // Captured pixel within line
	typedef logic [15:0] blank_pos_t;   // Cycles since vde
	typedef logic [3:0]  ade_count_t;   // Aux packets per line
	typedef logic [3:0]  aux_nibble_t;

	// Cycle position inside one aux packet
	typedef logic [$clog2(ADE_PACKET_LEN)-1:0] pkt_count_t;

	typedef enum logic {
		KIND_PIXEL,
		KIND_AUX
	} word_kind_t;

	typedef enum logic {
		GRANT_PIXEL,
		GRANT_AUX
	} grant_t;  // Last FIFO served

	////////////////////////////////////////
	// Records
	////////////////////////////////////////
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef struct packed {
		pix_count_t  hcount;
		line_count_t vcount;
	} raster_pos_t;

	typedef struct packed {
		logic [11:0] line;  // vcount, zero extended
		pix_index_t  index;
		rgb_t        rgb;
	} pixel_rec_t;

	typedef struct packed {
		blank_pos_t  pos;
		aux_nibble_t aux2;
		aux_nibble_t aux1;
		logic        aux0_b2;
	} aux_rec_t;

	// Aux records sit in the low payload bits
	typedef struct packed {
		word_kind_t           kind;
		logic [PAYLOAD_W-1:0] payload;
	} stream_word_t;

endpackage

// ==== logic/raster_tracker.sv ====
`timescale 1ns/1ps

module raster_tracker import capture_pkg::*; (
	input  logic        rx0_pclk,
	input  logic        RSTBTN,
	input  logic        hsync,
	input  logic        vsync,
	output raster_pos_t pos,
	output logic        hsync_rise,
	output logic        vsync_rise
);

	logic        hsync_q;  // Previous sampled levels
	logic        vsync_q;
	logic        h_edge;
	logic        v_edge;
	pix_count_t  hcount;
	line_count_t vcount;

	assign h_edge = hsync & ~hsync_q;
	assign v_edge = vsync & ~vsync_q;

	////////////////////////////////////////
	// Edge detect
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			hsync_q    <= 1'b0;
			vsync_q    <= 1'b0;
			hsync_rise <= 1'b0;
			vsync_rise <= 1'b0;
		end else begin
			hsync_q    <= hsync;
			vsync_q    <= vsync;
			hsync_rise <= h_edge;
			vsync_rise <= v_edge;
		end
	end

	////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			// Restart the line on hsync, hold at the end otherwise
			if (h_edge)
				hcount <= '0;
			else if (hcount != '1)
				hcount <= hcount + 1'b1;

			if (v_edge)
				vcount <= '0;  // New frame
			else if (h_edge)
				vcount <= vcount + 1'b1;
		end
	end

	assign pos = '{hcount: hcount, vcount: vcount};

endmodule

// ==== logic/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo import capture_pkg::*; #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_LOG2 = FIFO_DEPTH_LOG2
) (
	input  logic             rx0_pclk,
	input  logic             RSTBTN,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;

	// The reader drains one word per cycle so it never fills
	assign empty = (wr_ptr == rd_ptr);

	////////////////////////////////////////
	// Pointers
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	////////////////////////////////////////
	// Storage and output register
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
		if (rd_en && !empty)
			rd_data <= mem[rd_ptr];  // Valid the cycle after the strobe
	end

endmodule

// ==== logic/pixel_capture.sv ====
`timescale 1ns/1ps

module pixel_capture import capture_pkg::*; (
	input  logic        rx0_pclk,
	input  logic        RSTBTN,
	input  logic        vde,
	input  rgb_t        rgb,
	input  raster_pos_t pos,
	input  logic        hsync_rise,
	input  logic        rd_en,
	output pixel_rec_t  rd_data,
	output logic        empty
);

	rgb_t       rgb_q;  // Lines up with the registered pos
	pix_index_t index;
	logic       in_window;
	logic       capture;
	logic       wr_en;
	pixel_rec_t wr_rec;

	assign in_window = (pos.hcount >= pix_count_t'(H_WIN_FIRST)) &&
		(pos.hcount <= pix_count_t'(H_WIN_LAST));
	assign capture = vde && in_window;

	////////////////////////////////////////
	// In-line index and write strobe
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			index <= '0;
			wr_en <= 1'b0;
		end else begin
			wr_en <= capture;
			if (hsync_rise)
				index <= '0;  // New line
			else if (capture)
				index <= index + 1'b1;
		end
	end

	// Record payload
	always_ff @(posedge rx0_pclk) begin
		rgb_q <= rgb;
		if (capture) begin
			wr_rec.line  <= {1'b0, pos.vcount};
			wr_rec.index <= index;
			wr_rec.rgb   <= rgb_q;
		end
	end

	word_fifo #(
		.WIDTH ($bits(pixel_rec_t))
	) pix_fifo_i (
		.rx0_pclk (rx0_pclk),
		.RSTBTN   (RSTBTN),
		.wr_en    (wr_en),
		.wr_data  (wr_rec),
		.rd_en    (rd_en),
		.rd_data  (rd_data),
		.empty    (empty)
	);

endmodule

// ==== logic/aux_capture.sv ====
`timescale 1ns/1ps

module aux_capture import capture_pkg::*; (
	input  logic        rx0_pclk,
	input  logic        RSTBTN,
	input  logic        vde,
	input  logic        ade,
	input  aux_nibble_t aux0,
	input  aux_nibble_t aux1,
	input  aux_nibble_t aux2,
	input  logic        hsync_rise,
	input  logic        rd_en,
	output aux_rec_t    rd_data,
	output logic        empty,
	output ade_count_t  ade_num
);

	blank_pos_t blank_pos;
	logic       armed;     // Video seen since reset
	pkt_count_t pkt_cnt;
	ade_count_t line_cnt;  // Packets on the current line
	logic       wr_en;
	aux_rec_t   wr_rec;

	////////////////////////////////////////
	// Blanking position
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			blank_pos <= '0;
			armed     <= 1'b0;
		end else begin
			if (vde)
				blank_pos <= '0;
			else
				blank_pos <= blank_pos + 1'b1;  // Wraps in long blanking

			if (vde)
				armed <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Aux packet counting
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			pkt_cnt  <= '0;
			line_cnt <= '0;
			ade_num  <= '0;
		end else begin
			if (!ade)
				pkt_cnt <= '0;
			else if (pkt_cnt == pkt_count_t'(ADE_PACKET_LEN - 1))
				pkt_cnt <= '0;
			else
				pkt_cnt <= pkt_cnt + 1'b1;

			// Latch the finished line, then start over
			if (hsync_rise) begin
				ade_num  <= line_cnt;
				line_cnt <= '0;
			end else if (ade && pkt_cnt == '0) begin
				line_cnt <= line_cnt + 1'b1;  // First cycle of a packet
			end
		end
	end

	////////////////////////////////////////
	// Aux record
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			wr_en <= 1'b0;
		else
			wr_en <= armed && ade;
	end

	// Samples and position taken together
	always_ff @(posedge rx0_pclk) begin
		wr_rec.pos     <= blank_pos;
		wr_rec.aux2    <= aux2;
		wr_rec.aux1    <= aux1;
		wr_rec.aux0_b2 <= aux0[2];
	end

	word_fifo #(
		.WIDTH ($bits(aux_rec_t))
	) aux_fifo_i (
		.rx0_pclk (rx0_pclk),
		.RSTBTN   (RSTBTN),
		.wr_en    (wr_en),
		.wr_data  (wr_rec),
		.rd_en    (rd_en),
		.rd_data  (rd_data),
		.empty    (empty)
	);

endmodule

// ==== logic/stream_arbiter.sv ====
`timescale 1ns/1ps

module stream_arbiter import capture_pkg::*; (
	input  logic         rx0_pclk,
	input  logic         RSTBTN,
	input  logic         pix_empty,
	input  pixel_rec_t   pix_data,
	output logic         pix_rd_en,
	input  logic         aux_empty,
	input  aux_rec_t     aux_data,
	output logic         aux_rd_en,
	output logic         out_valid,
	output stream_word_t out_word
);

	grant_t     last_grant;
	word_kind_t kind_q;  // Source of the word now on rd_data

	////////////////////////////////////////
	// Round robin
	////////////////////////////////////////
	// Aux goes when alone or when pixel had the last turn
	assign aux_rd_en = !aux_empty && (pix_empty || last_grant == GRANT_PIXEL);
	assign pix_rd_en = !pix_empty && !aux_rd_en;

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			last_grant <= GRANT_PIXEL;
			out_valid  <= 1'b0;
			kind_q     <= KIND_PIXEL;
		end else begin
			out_valid <= pix_rd_en || aux_rd_en;
			if (aux_rd_en) begin
				last_grant <= GRANT_AUX;
				kind_q     <= KIND_AUX;
			end else if (pix_rd_en) begin
				last_grant <= GRANT_PIXEL;
				kind_q     <= KIND_PIXEL;
			end
		end
	end

	////////////////////////////////////////
	// Output word
	////////////////////////////////////////
	always_comb begin
		out_word.kind    = kind_q;
		out_word.payload = '0;
		if (kind_q == KIND_AUX)
			out_word.payload[$bits(aux_rec_t)-1:0] = aux_data;
		else
			out_word.payload = pix_data;
	end

endmodule

// ==== logic/capture_top.sv ====
`timescale 1ns/1ps

module capture_top import capture_pkg::*; (
	input  logic         rx0_pclk,
	input  logic         RSTBTN,
	input  logic         hsync,
	input  logic         vsync,
	input  logic         vde,
	input  logic         ade,
	input  rgb_t         rgb,
	input  aux_nibble_t  aux0,
	input  aux_nibble_t  aux1,
	input  aux_nibble_t  aux2,
	output logic         out_valid,
	output stream_word_t out_word,
	output ade_count_t   ade_num
);

	raster_pos_t pos;
	logic        hsync_rise;
	logic        pix_rd_en;
	logic        pix_empty;
	pixel_rec_t  pix_data;
	logic        aux_rd_en;
	logic        aux_empty;
	aux_rec_t    aux_data;

	raster_tracker raster_i (
		.rx0_pclk   (rx0_pclk),
		.RSTBTN     (RSTBTN),
		.hsync      (hsync),
		.vsync      (vsync),
		.pos        (pos),
		.hsync_rise (hsync_rise),
		.vsync_rise ()  // Not needed by the capture paths
	);

	pixel_capture pixel_i (
		.rx0_pclk   (rx0_pclk),
		.RSTBTN     (RSTBTN),
		.vde        (vde),
		.rgb        (rgb),
		.pos        (pos),
		.hsync_rise (hsync_rise),
		.rd_en      (pix_rd_en),
		.rd_data    (pix_data),
		.empty      (pix_empty)
	);

	aux_capture aux_i (
		.rx0_pclk   (rx0_pclk),
		.RSTBTN     (RSTBTN),
		.vde        (vde),
		.ade        (ade),
		.aux0       (aux0),
		.aux1       (aux1),
		.aux2       (aux2),
		.hsync_rise (hsync_rise),
		.rd_en      (aux_rd_en),
		.rd_data    (aux_data),
		.empty      (aux_empty),
		.ade_num    (ade_num)
	);

	stream_arbiter arb_i (
		.rx0_pclk  (rx0_pclk),
		.RSTBTN    (RSTBTN),
		.pix_empty (pix_empty),
		.pix_data  (pix_data),
		.pix_rd_en (pix_rd_en),
		.aux_empty (aux_empty),
		.aux_data  (aux_data),
		.aux_rd_en (aux_rd_en),
		.out_valid (out_valid),
		.out_word  (out_word)
	);

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import capture_pkg::*; ();

	localparam int LINE_LEN      = 1500;
	localparam int LINES         = 8;     // Per frame
	localparam int FRAMES        = 2;
	localparam int VDE_FIRST     = 181;   // Drive position, DUT hcount runs one behind
	localparam int VDE_LAST      = 1461;
	localparam int ADE_START     = 60;
	localparam int HSYNC_LEN     = 16;
	localparam int DRAIN_TIMEOUT = 500;

	logic         rx0_pclk = 1'b0;
	logic         RSTBTN;
	logic         hsync;
	logic         vsync;
	logic         vde;
	logic         ade;
	rgb_t         rgb;
	aux_nibble_t  aux0;
	aux_nibble_t  aux1;
	aux_nibble_t  aux2;
	logic         out_valid;
	stream_word_t out_word;
	ade_count_t   ade_num;

	logic [31:0] lfsr_state;
	int          value_errors = 0;
	int          other_errors = 0;
	int          pix_words = 0;
	int          aux_words = 0;
	int          exp_pix_words = 0;
	int          exp_aux_words = 0;
	int          kind_switches = 0;
	word_kind_t  last_kind;
	logic        have_last_kind = 1'b0;
	logic        reset_seen = 1'b0;
	int          reset_checks_left = 0;

	// Reference model state
	logic        m_hsync_q;
	logic        m_vsync_q;
	logic        m_hrise;
	pix_count_t  m_hcount;
	line_count_t m_vcount;
	pix_index_t  m_index;
	rgb_t        m_rgb_q;
	blank_pos_t  m_blank_pos;
	logic        m_armed;
	int          m_pkt;
	ade_count_t  m_line_cnt;
	ade_count_t  m_ade_num = '0;
	logic        ade_pending = 1'b0;  // ade_num due next cycle
	pixel_rec_t  pix_q[$];
	aux_rec_t    aux_q[$];

	always #50 rx0_pclk = ~rx0_pclk;

	capture_top dut_i (
		.rx0_pclk  (rx0_pclk),
		.RSTBTN    (RSTBTN),
		.hsync     (hsync),
		.vsync     (vsync),
		.vde       (vde),
		.ade       (ade),
		.rgb       (rgb),
		.aux0      (aux0),
		.aux1      (aux1),
		.aux2      (aux2),
		.out_valid (out_valid),
		.out_word  (out_word),
		.ade_num   (ade_num)
	);

	////////////////////////////////////////
	// Random source
	////////////////////////////////////////
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};  // One step per bit
		end
		return v;
	endfunction

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic check_pixel(input pixel_rec_t got);
		pixel_rec_t exp;
		if (pix_q.size() == 0) begin
			$display("Pixel word %h arrived with no pixel record expected", got);
			other_errors++;
		end else begin
			exp = pix_q.pop_front();
			if (got !== exp) begin
				$display("[FAIL] out_word.payload (pixel) expected %h got %h", exp, got);
				value_errors++;
			end
		end
	endtask

	task automatic check_aux(input aux_rec_t got);
		aux_rec_t exp;
		if (aux_q.size() == 0) begin
			$display("Aux word %h arrived with no aux record expected", got);
			other_errors++;
		end else begin
			exp = aux_q.pop_front();
			if (got !== exp) begin
				$display("[FAIL] out_word.payload (aux) expected %h got %h", exp, got);
				value_errors++;
			end
		end
	endtask

	task automatic check_ade_num(input ade_count_t got);
		if (got !== m_ade_num) begin
			$display("[FAIL] ade_num expected %h got %h", m_ade_num, got);
			value_errors++;
		end
	endtask

	// Values seen here were set at the previous edge
	task automatic observe_outputs();
		pixel_rec_t prec;
		aux_rec_t   arec;
		if (reset_seen && reset_checks_left > 0) begin
			if (out_valid !== 1'b0) begin
				$display("[FAIL] out_valid expected 0 got %h", out_valid);
				value_errors++;
			end
			check_ade_num(ade_num);
		end
		if (RSTBTN) begin
			reset_seen = 1'b1;
			reset_checks_left = 2;  // Reset edge and the cycle after it
		end else if (reset_checks_left > 0) begin
			reset_checks_left--;
		end
		if (ade_pending) begin
			check_ade_num(ade_num);
			ade_pending = 1'b0;
		end
		if (out_valid === 1'b1) begin
			if (out_word.kind === KIND_PIXEL) begin
				prec = out_word.payload;
				check_pixel(prec);
				pix_words++;
			end else if (out_word.kind === KIND_AUX) begin
				arec = out_word.payload[$bits(aux_rec_t)-1:0];
				check_aux(arec);
				if (out_word.payload[PAYLOAD_W-1:$bits(aux_rec_t)] !== '0) begin
					$display("[FAIL] out_word.payload upper bits expected 0 got %h",
						out_word.payload[PAYLOAD_W-1:$bits(aux_rec_t)]);
					value_errors++;
				end
				aux_words++;
			end else begin
				$display("Output word has an unknown kind");
				other_errors++;
			end
			if (have_last_kind && out_word.kind !== last_kind)
				kind_switches++;
			last_kind = out_word.kind;
			have_last_kind = 1'b1;
		end
	endtask

	////////////////////////////////////////
	// Reference model, one step per edge
	////////////////////////////////////////
	task automatic model_step();
		logic       h_edge;
		logic       v_edge;
		logic       capture;
		pixel_rec_t prec;
		aux_rec_t   arec;
		h_edge = hsync & ~m_hsync_q;
		v_edge = vsync & ~m_vsync_q;
		capture = vde && int'(m_hcount) >= H_WIN_FIRST && int'(m_hcount) <= H_WIN_LAST;
		if (RSTBTN) begin
			m_hsync_q   = 1'b0;
			m_vsync_q   = 1'b0;
			m_hrise     = 1'b0;
			m_hcount    = '0;
			m_vcount    = '0;
			m_index     = '0;
			m_blank_pos = '0;
			m_armed     = 1'b0;
			m_pkt       = 0;
			m_line_cnt  = '0;
			m_ade_num   = '0;
			ade_pending = 1'b0;
		end else begin
			if (capture) begin
				prec.line  = {1'b0, m_vcount};
				prec.index = m_index;
				prec.rgb   = m_rgb_q;
				pix_q.push_back(prec);
			end
			if (m_armed && ade) begin
				arec.pos     = m_blank_pos;
				arec.aux2    = aux2;
				arec.aux1    = aux1;
				arec.aux0_b2 = aux0[2];
				aux_q.push_back(arec);
			end
			if (m_hrise) begin
				m_ade_num   = m_line_cnt;  // Count of the finished line
				m_line_cnt  = '0;
				ade_pending = 1'b1;
			end else if (ade && m_pkt == 0) begin
				m_line_cnt = m_line_cnt + 1'b1;
			end
			if (!ade || m_pkt == ADE_PACKET_LEN - 1)
				m_pkt = 0;
			else
				m_pkt++;
			if (m_hrise)
				m_index = '0;
			else if (capture)
				m_index = m_index + 1'b1;
			m_blank_pos = vde ? '0 : m_blank_pos + 1'b1;
			m_armed = m_armed | vde;
			m_hrise = h_edge;
			if (h_edge)
				m_hcount = '0;
			else if (m_hcount != '1)
				m_hcount = m_hcount + 1'b1;
			if (v_edge)
				m_vcount = '0;
			else if (h_edge)
				m_vcount = m_vcount + 1'b1;
			m_hsync_q = hsync;
			m_vsync_q = vsync;
		end
		m_rgb_q = rgb;
	endtask

	always @(posedge rx0_pclk) begin
		observe_outputs();
		model_step();
	end

	task automatic wait_for_drain();
		int n;
		n = 0;
		while ((pix_q.size() != 0 || aux_q.size() != 0) && n < DRAIN_TIMEOUT) begin
			@(negedge rx0_pclk);
			n++;
		end
		if (pix_q.size() != 0 || aux_q.size() != 0) begin
			$display("Timeout while draining: %0d pixel and %0d aux records never came out",
				pix_q.size(), aux_q.size());
			other_errors++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus and report
	////////////////////////////////////////
	initial begin
		int          burst_len;
		logic [31:0] r;
		RSTBTN <= 1'b1;
		hsync  <= 1'b0;
		vsync  <= 1'b0;
		vde    <= 1'b0;
		ade    <= 1'b0;
		rgb    <= '0;
		aux0   <= '0;
		aux1   <= '0;
		aux2   <= '0;
		lfsr_state = 32'hcc41_4065;
		exp_pix_words = FRAMES * 4 * (H_WIN_LAST - H_WIN_FIRST + 1);
		repeat (16) @(posedge rx0_pclk);
		RSTBTN <= 1'b0;

		for (int f = 0; f < FRAMES; f++) begin
			for (int line_no = 0; line_no < LINES; line_no++) begin
				r = take_bits(2);
				burst_len = (int'(r[1:0]) % 3 + 1) * ADE_PACKET_LEN;
				if (f > 0 || line_no >= 3)
					exp_aux_words += burst_len;  // Armed by video on line 2
				for (int h = 0; h < LINE_LEN; h++) begin
					@(posedge rx0_pclk);
					hsync <= (h < HSYNC_LEN);
					vsync <= (line_no == 0);
					vde   <= (line_no >= 2 && line_no <= 5 && h >= VDE_FIRST && h <= VDE_LAST);
					ade   <= (h >= ADE_START && h < ADE_START + burst_len);
					r = take_bits(24);
					rgb <= r[23:0];
					r = take_bits(12);
					aux0 <= r[3:0];
					aux1 <= r[7:4];
					aux2 <= r[11:8];
				end
			end
		end

		@(posedge rx0_pclk);
		hsync <= 1'b0;
		vsync <= 1'b0;
		vde   <= 1'b0;
		ade   <= 1'b0;
		wait_for_drain();
		repeat (64) @(negedge rx0_pclk);  // Any word now is extra

		if (pix_words != exp_pix_words) begin
			$display("Pixel word count is %0d, %0d expected", pix_words, exp_pix_words);
			other_errors++;
		end
		if (aux_words != exp_aux_words) begin
			$display("Aux word count is %0d, %0d expected", aux_words, exp_aux_words);
			other_errors++;
		end
		if (kind_switches == 0) begin
			$display("Pixel and aux words never interleaved on the output");
			other_errors++;
		end
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
logic/capture_pkg.sv
logic/raster_tracker.sv
logic/word_fifo.sv
logic/pixel_capture.sv
logic/aux_capture.sv
logic/stream_arbiter.sv
logic/capture_top.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "Simulation reported errors"
	exit 1
fi
echo "Simulation finished without errors"
